/* hw/cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP   = 5'b00000,
		OP_B     = 5'b00010,
		OP_BEQZ  = 5'b00100,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_RTYPE = 5'b11100,
		OP_JR    = 5'b11101
	} opcode_e;

	// R-type function, bits 2..0
	typedef enum logic [2:0] {
		F_ADDU = 3'b001,
		F_SLT  = 3'b010,
		F_SUBU = 3'b011,
		F_AND  = 3'b100,
		F_OR   = 3'b101
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_SLT   = 3'd4,
		ALU_PASSB = 3'd5
	} alu_op_e;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   res
);

	logic less;

	// Signed compare for SLT
	assign less = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD:   res = a + b;
			cpu_pkg::ALU_SUB:   res = a - b;
			cpu_pkg::ALU_AND:   res = a & b;
			cpu_pkg::ALU_OR:    res = a | b;
			cpu_pkg::ALU_SLT:   res = {15'd0, less};
			cpu_pkg::ALU_PASSB: res = b;
			default:            res = '0;
		endcase
	end

endmodule

/* hw/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
	parameter int WORDS = 256
) (
	input  logic           clk,
	input  logic           we,
	input  cpu_pkg::word_t waddr,
	input  cpu_pkg::word_t wdata,
	input  cpu_pkg::word_t raddr,
	output cpu_pkg::word_t rdata
);

	localparam int AW = $clog2(WORDS);

	cpu_pkg::word_t mem [WORDS];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr[AW-1:0]] <= wdata;
		end
	end

	// Asynchronous read
	assign rdata = mem[raddr[AW-1:0]];

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  cpu_pkg::word_t     wr_value,
	input  cpu_pkg::reg_addr_t rd_addr1,
	input  cpu_pkg::reg_addr_t rd_addr2,
	output cpu_pkg::word_t     rd_value1,
	output cpu_pkg::word_t     rd_value2
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr) begin
			regs[wr_addr] <= wr_value;
		end
	end

	// Write-back result visible to decode in the same cycle
	assign rd_value1 = (wr && wr_addr == rd_addr1) ? wr_value : regs[rd_addr1];
	assign rd_value2 = (wr && wr_addr == rd_addr2) ? wr_value : regs[rd_addr2];

endmodule

/* hw/bootloader.sv */
`timescale 1ns/1ps

module bootloader #(
	parameter int BOOT_WORDS = 64
) (
	input  logic           clk,
	input  logic           rst_n,
	input  cpu_pkg::word_t flash_data,
	input  logic           flash_ready,
	output cpu_pkg::word_t flash_addr,
	output logic           flash_rd,
	output logic           init_we,
	output cpu_pkg::word_t init_addr,
	output cpu_pkg::word_t init_data,
	output logic           boot_done
);

	typedef enum logic [1:0] {
		REQUEST,
		WAIT,
		WRITE
	} state_t;

	state_t         state;
	cpu_pkg::word_t count;
	logic           last_word;

	assign last_word = (count == cpu_pkg::word_t'(BOOT_WORDS - 1));

	// Same word index for the flash read and the imem write
	assign flash_addr = count;
	assign init_addr = count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= REQUEST;
			count <= '0;
			flash_rd <= 1'b0;
			init_we <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				REQUEST: begin
					flash_rd <= 1'b1;
					state <= WAIT;
				end
				WAIT: begin
					flash_rd <= 1'b0;
					if (flash_ready) begin
						init_we <= 1'b1;
						state <= WRITE;
					end
				end
				WRITE: begin
					init_we <= 1'b0;
					if (last_word) begin
						boot_done <= 1'b1;
					end else begin
						// Next read issued right after the write
						count <= count + 16'd1;
						flash_rd <= 1'b1;
						state <= WAIT;
					end
				end
				default: state <= REQUEST;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT && flash_ready) begin
			init_data <= flash_data;
		end
	end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
	parameter int IMEM_WORDS = 256
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           boot_done,
	input  logic           redirect,
	input  cpu_pkg::word_t redirect_pc,
	input  cpu_pkg::word_t imem_rdata,
	output cpu_pkg::word_t imem_raddr,
	output cpu_pkg::word_t id_inst,
	output cpu_pkg::word_t id_pc
);

	cpu_pkg::word_t pc_q;
	cpu_pkg::word_t pc_next;

	assign imem_raddr = pc_q;

	// Delay slot already in flight, only the following fetch moves
	assign pc_next = redirect ? redirect_pc : pc_q + 16'd1;

	always_ff @(posedge clk) begin
		if (!rst_n || !boot_done) begin
			pc_q <= '0;
			id_inst <= {cpu_pkg::OP_NOP, 11'd0};
			id_pc <= '0;
		end else begin
			pc_q <= cpu_pkg::word_t'(pc_next % IMEM_WORDS);
			id_inst <= imem_rdata;
			id_pc <= pc_q;
		end
	end

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     id_inst,
	input  cpu_pkg::word_t     id_pc,
	input  cpu_pkg::word_t     rd_value1,
	input  cpu_pkg::word_t     rd_value2,
	output cpu_pkg::reg_addr_t rd_addr1,
	output cpu_pkg::reg_addr_t rd_addr2,
	output logic               redirect,
	output cpu_pkg::word_t     redirect_pc,
	output cpu_pkg::alu_op_e   ex_alu_op,
	output cpu_pkg::word_t     ex_op_a,
	output cpu_pkg::word_t     ex_op_b,
	output cpu_pkg::word_t     ex_store_data,
	output logic               ex_mem_rd,
	output logic               ex_mem_wr,
	output logic               ex_reg_wr,
	output cpu_pkg::reg_addr_t ex_reg_addr
);

	cpu_pkg::opcode_e   opcode;
	cpu_pkg::funct_e    funct;
	cpu_pkg::reg_addr_t rz;
	cpu_pkg::word_t     imm8_z;
	cpu_pkg::word_t     imm8_s;
	cpu_pkg::word_t     imm5_s;
	cpu_pkg::word_t     imm11_s;
	cpu_pkg::word_t     pc_plus1;
	cpu_pkg::alu_op_e   alu_op;
	cpu_pkg::word_t     op_a;
	cpu_pkg::word_t     op_b;
	logic               mem_rd;
	logic               mem_wr;
	logic               reg_wr;
	cpu_pkg::reg_addr_t reg_addr;

	assign opcode = cpu_pkg::opcode_e'(id_inst[15:11]);
	assign funct = cpu_pkg::funct_e'(id_inst[2:0]);
	assign rd_addr1 = id_inst[10:8];
	assign rd_addr2 = id_inst[7:5];
	assign rz = id_inst[4:2];

	assign imm8_z = {8'd0, id_inst[7:0]};
	assign imm8_s = {{8{id_inst[7]}}, id_inst[7:0]};
	assign imm5_s = {{11{id_inst[4]}}, id_inst[4:0]};
	assign imm11_s = {{5{id_inst[10]}}, id_inst[10:0]};
	assign pc_plus1 = id_pc + 16'd1;

	always_comb begin
		alu_op = cpu_pkg::ALU_ADD;
		op_a = rd_value1;
		op_b = '0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		reg_wr = 1'b0;
		reg_addr = rd_addr1;
		redirect = 1'b0;
		redirect_pc = pc_plus1 + imm8_s;
		case (opcode)
			cpu_pkg::OP_LI: begin
				alu_op = cpu_pkg::ALU_PASSB;
				op_b = imm8_z;
				reg_wr = 1'b1;
			end
			cpu_pkg::OP_ADDIU: begin
				op_b = imm8_s;
				reg_wr = 1'b1;
			end
			cpu_pkg::OP_RTYPE: begin
				op_b = rd_value2;
				reg_addr = rz;
				reg_wr = 1'b1;
				case (funct)
					cpu_pkg::F_ADDU: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::F_SUBU: alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::F_AND:  alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::F_OR:   alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::F_SLT:  alu_op = cpu_pkg::ALU_SLT;
					default:         reg_wr = 1'b0;
				endcase
			end
			// Address is ry plus imm5
			cpu_pkg::OP_LW: begin
				op_a = rd_value2;
				op_b = imm5_s;
				mem_rd = 1'b1;
				reg_wr = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				op_a = rd_value2;
				op_b = imm5_s;
				mem_wr = 1'b1;
			end
			cpu_pkg::OP_B: begin
				redirect = 1'b1;
				redirect_pc = pc_plus1 + imm11_s;
			end
			cpu_pkg::OP_BEQZ: redirect = (rd_value1 == '0);
			cpu_pkg::OP_JR: begin
				redirect = 1'b1;
				redirect_pc = rd_value1;
			end
			// NOP and undefined opcodes
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem_rd <= 1'b0;
			ex_mem_wr <= 1'b0;
			ex_reg_wr <= 1'b0;
		end else begin
			ex_mem_rd <= mem_rd;
			ex_mem_wr <= mem_wr;
			ex_reg_wr <= reg_wr;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op <= alu_op;
		ex_op_a <= op_a;
		ex_op_b <= op_b;
		ex_store_data <= rd_value1;
		ex_reg_addr <= reg_addr;
	end

endmodule

/* hw/zhxpu.sv */
`timescale 1ns/1ps

module zhxpu #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256,
	parameter int BOOT_WORDS = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	output cpu_pkg::word_t     flash_addr,
	output logic               flash_rd,
	input  cpu_pkg::word_t     flash_data,
	input  logic               flash_ready,
	output logic               boot_done,
	output logic               reg_wr,
	output cpu_pkg::reg_addr_t reg_wr_addr,
	output cpu_pkg::word_t     reg_wr_value
);

	logic               init_we;
	cpu_pkg::word_t     init_addr;
	cpu_pkg::word_t     init_data;
	cpu_pkg::word_t     imem_raddr;
	cpu_pkg::word_t     imem_rdata;
	cpu_pkg::word_t     id_inst;
	cpu_pkg::word_t     id_pc;
	logic               redirect;
	cpu_pkg::word_t     redirect_pc;
	cpu_pkg::reg_addr_t rd_addr1;
	cpu_pkg::reg_addr_t rd_addr2;
	cpu_pkg::word_t     rd_value1;
	cpu_pkg::word_t     rd_value2;
	cpu_pkg::alu_op_e   ex_alu_op;
	cpu_pkg::word_t     ex_op_a;
	cpu_pkg::word_t     ex_op_b;
	cpu_pkg::word_t     ex_store_data;
	logic               ex_mem_rd;
	logic               ex_mem_wr;
	logic               ex_reg_wr;
	cpu_pkg::reg_addr_t ex_reg_addr;
	cpu_pkg::word_t     alu_res;
	cpu_pkg::word_t     dmem_rdata;

	bootloader #(.BOOT_WORDS(BOOT_WORDS)) __bootloader (
		.clk(clk),
		.rst_n(rst_n),
		.flash_data(flash_data),
		.flash_ready(flash_ready),
		.flash_addr(flash_addr),
		.flash_rd(flash_rd),
		.init_we(init_we),
		.init_addr(init_addr),
		.init_data(init_data),
		.boot_done(boot_done)
	);

	word_ram #(.WORDS(IMEM_WORDS)) __imem (
		.clk(clk),
		.we(init_we),
		.waddr(init_addr),
		.wdata(init_data),
		.raddr(imem_raddr),
		.rdata(imem_rdata)
	);

	fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) __fetch_unit (
		.clk(clk),
		.rst_n(rst_n),
		.boot_done(boot_done),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_rdata(imem_rdata),
		.imem_raddr(imem_raddr),
		.id_inst(id_inst),
		.id_pc(id_pc)
	);

	decode_unit __decode_unit (
		.clk(clk),
		.rst_n(rst_n),
		.id_inst(id_inst),
		.id_pc(id_pc),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_alu_op(ex_alu_op),
		.ex_op_a(ex_op_a),
		.ex_op_b(ex_op_b),
		.ex_store_data(ex_store_data),
		.ex_mem_rd(ex_mem_rd),
		.ex_mem_wr(ex_mem_wr),
		.ex_reg_wr(ex_reg_wr),
		.ex_reg_addr(ex_reg_addr)
	);

	register_file __register_file (
		.clk(clk),
		.rst_n(rst_n),
		.wr(ex_reg_wr),
		.wr_addr(ex_reg_addr),
		.wr_value(reg_wr_value),
		.rd_addr1(rd_addr1),
		.rd_addr2(rd_addr2),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2)
	);

	alu __alu (
		.op(ex_alu_op),
		.a(ex_op_a),
		.b(ex_op_b),
		.res(alu_res)
	);

	// ALU result doubles as the data address
	word_ram #(.WORDS(DMEM_WORDS)) __dmem (
		.clk(clk),
		.we(ex_mem_wr),
		.waddr(alu_res),
		.wdata(ex_store_data),
		.raddr(alu_res),
		.rdata(dmem_rdata)
	);

	// Write-back select and debug port
	assign reg_wr_value = ex_mem_rd ? dmem_rdata : alu_res;
	assign reg_wr = ex_reg_wr;
	assign reg_wr_addr = ex_reg_addr;

endmodule

/* verification/zhxpu_tb.sv */
`timescale 1ns/1ps

module zhxpu_tb;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int BOOT_WORDS = 64;

	logic               clk;
	logic               rst_n;
	cpu_pkg::word_t     flash_addr;
	logic               flash_rd;
	cpu_pkg::word_t     flash_data = '0;
	logic               flash_ready = 1'b0;
	logic               boot_done;
	logic               reg_wr;
	cpu_pkg::reg_addr_t reg_wr_addr;
	cpu_pkg::word_t     reg_wr_value;

	cpu_pkg::word_t     image [BOOT_WORDS];
	cpu_pkg::reg_addr_t exp_addr_q [$];
	cpu_pkg::word_t     exp_value_q [$];
	int                 exp_idx = 0;
	int                 cycles = 0;
	int                 limit = 0;
	integer             seed;

	// Flash model state
	bit                 pending = 1'b0;
	int                 delay = 0;
	cpu_pkg::word_t     req_addr = '0;
	cpu_pkg::word_t     next_addr = '0;
	int                 reads = 0;
	logic               prev_boot = 1'b0;

	zhxpu #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS),
		.BOOT_WORDS(BOOT_WORDS)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.flash_addr(flash_addr),
		.flash_rd(flash_rd),
		.flash_data(flash_data),
		.flash_ready(flash_ready),
		.boot_done(boot_done),
		.reg_wr(reg_wr),
		.reg_wr_addr(reg_wr_addr),
		.reg_wr_value(reg_wr_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input cpu_pkg::word_t got,
			input cpu_pkg::word_t expected);
		if (got !== expected) begin
			abort_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	function automatic cpu_pkg::word_t itype(input logic [4:0] op, input cpu_pkg::reg_addr_t rx,
			input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic cpu_pkg::word_t mtype(input logic [4:0] op, input cpu_pkg::reg_addr_t rx,
			input cpu_pkg::reg_addr_t ry, input logic [4:0] imm);
		return {op, rx, ry, imm};
	endfunction

	// Bit 0 of rz is shared with bit 2 of funct
	function automatic cpu_pkg::word_t rtype(input cpu_pkg::reg_addr_t rx,
			input cpu_pkg::reg_addr_t ry, input cpu_pkg::reg_addr_t rz, input logic [2:0] f);
		return {cpu_pkg::OP_RTYPE, rx, ry, rz[2:1], f};
	endfunction

	function automatic void load_program();
		for (int i = 0; i < BOOT_WORDS; i++) begin
			image[i] = '0;
		end
		// Immediates
		image[0] = itype(cpu_pkg::OP_LI, 3'd1, 8'h7F);
		image[1] = itype(cpu_pkg::OP_LI, 3'd2, 8'hF0);
		image[2] = itype(cpu_pkg::OP_ADDIU, 3'd2, 8'h85);
		image[3] = itype(cpu_pkg::OP_ADDIU, 3'd1, 8'h01);
		image[4] = itype(cpu_pkg::OP_LI, 3'd3, 8'h80);
		image[5] = itype(cpu_pkg::OP_ADDIU, 3'd3, 8'h80);
		// R-type chain where each uses the previous result
		image[6] = rtype(3'd1, 3'd2, 3'd4, cpu_pkg::F_ADDU);
		image[7] = rtype(3'd3, 3'd4, 3'd6, cpu_pkg::F_SUBU);
		image[8] = rtype(3'd6, 3'd1, 3'd7, cpu_pkg::F_OR);
		image[9] = rtype(3'd7, 3'd4, 3'd5, cpu_pkg::F_AND);
		image[10] = rtype(3'd5, 3'd7, 3'd2, cpu_pkg::F_ADDU);
		image[11] = rtype(3'd7, 3'd2, 3'd6, cpu_pkg::F_SLT);
		image[12] = rtype(3'd6, 3'd7, 3'd0, cpu_pkg::F_SLT);
		image[13] = rtype(3'd0, 3'd5, 3'd6, cpu_pkg::F_SUBU);
		// Stores and loads including an offset of -1
		image[14] = itype(cpu_pkg::OP_LI, 3'd1, 8'h10);
		image[15] = mtype(cpu_pkg::OP_SW, 3'd4, 3'd1, 5'd0);
		image[16] = mtype(cpu_pkg::OP_SW, 3'd5, 3'd1, 5'd1);
		image[17] = mtype(cpu_pkg::OP_SW, 3'd6, 3'd1, 5'h1F);
		image[18] = mtype(cpu_pkg::OP_LW, 3'd2, 3'd1, 5'h1F);
		image[19] = mtype(cpu_pkg::OP_LW, 3'd3, 3'd1, 5'd1);
		image[20] = mtype(cpu_pkg::OP_LW, 3'd4, 3'd1, 5'd0);
		// Branches each followed by a writing delay slot
		image[21] = itype(cpu_pkg::OP_BEQZ, 3'd3, 8'd5);
		image[22] = itype(cpu_pkg::OP_LI, 3'd5, 8'h01);
		image[23] = itype(cpu_pkg::OP_LI, 3'd6, 8'h00);
		image[24] = itype(cpu_pkg::OP_BEQZ, 3'd6, 8'd3);
		image[25] = itype(cpu_pkg::OP_LI, 3'd5, 8'h02);
		image[26] = itype(cpu_pkg::OP_LI, 3'd7, 8'hEE);
		image[27] = itype(cpu_pkg::OP_LI, 3'd7, 8'hDD);
		image[28] = {cpu_pkg::OP_B, 11'd3};
		image[29] = itype(cpu_pkg::OP_ADDIU, 3'd5, 8'h01);
		image[30] = itype(cpu_pkg::OP_LI, 3'd7, 8'hAA);
		image[31] = itype(cpu_pkg::OP_LI, 3'd7, 8'hBB);
		// Counted loop with a backward B
		image[32] = itype(cpu_pkg::OP_LI, 3'd6, 8'h03);
		image[33] = itype(cpu_pkg::OP_ADDIU, 3'd6, 8'hFF);
		image[34] = itype(cpu_pkg::OP_BEQZ, 3'd6, 8'd3);
		image[35] = itype(cpu_pkg::OP_ADDIU, 3'd5, 8'h10);
		image[36] = {cpu_pkg::OP_B, 11'h7FC};
		image[37] = itype(cpu_pkg::OP_ADDIU, 3'd7, 8'h01);
		image[38] = itype(cpu_pkg::OP_LI, 3'd1, 8'd42);
		image[39] = itype(cpu_pkg::OP_JR, 3'd1, 8'd0);
		image[40] = itype(cpu_pkg::OP_LI, 3'd2, 8'h55);
		image[41] = itype(cpu_pkg::OP_LI, 3'd2, 8'h66);
		image[42] = rtype(3'd2, 3'd5, 3'd6, cpu_pkg::F_ADDU);
		// Halt loop with a NOP in its delay slot
		image[43] = {cpu_pkg::OP_B, 11'h7FF};
	endfunction

	// ISA model with one delay slot per branch
	function automatic void execute_ref();
		cpu_pkg::word_t     r [8];
		cpu_pkg::word_t     dm [DMEM_WORDS];
		cpu_pkg::word_t     pc;
		cpu_pkg::word_t     npc;
		cpu_pkg::word_t     target;
		cpu_pkg::word_t     inst;
		cpu_pkg::word_t     imm8s;
		cpu_pkg::word_t     imm5s;
		cpu_pkg::word_t     imm11s;
		cpu_pkg::word_t     addr;
		cpu_pkg::word_t     res;
		cpu_pkg::reg_addr_t rx;
		cpu_pkg::reg_addr_t ry;
		cpu_pkg::reg_addr_t dst;
		logic               wr;
		for (int i = 0; i < 8; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dm[i] = '0;
		end
		pc = '0;
		npc = 16'd1;
		for (int step = 0; step < 1000; step++) begin
			inst = image[pc % BOOT_WORDS];
			if (inst == {cpu_pkg::OP_B, 11'h7FF}) begin
				break;
			end
			rx = inst[10:8];
			ry = inst[7:5];
			imm8s = {{8{inst[7]}}, inst[7:0]};
			imm5s = {{11{inst[4]}}, inst[4:0]};
			imm11s = {{5{inst[10]}}, inst[10:0]};
			addr = r[ry] + imm5s;
			target = npc + 16'd1;
			wr = 1'b1;
			dst = rx;
			res = '0;
			case (inst[15:11])
				cpu_pkg::OP_LI: res = {8'd0, inst[7:0]};
				cpu_pkg::OP_ADDIU: res = r[rx] + imm8s;
				cpu_pkg::OP_RTYPE: begin
					dst = inst[4:2];
					case (inst[2:0])
						cpu_pkg::F_ADDU: res = r[rx] + r[ry];
						cpu_pkg::F_SUBU: res = r[rx] - r[ry];
						cpu_pkg::F_AND: res = r[rx] & r[ry];
						cpu_pkg::F_OR: res = r[rx] | r[ry];
						cpu_pkg::F_SLT: res = ($signed(r[rx]) < $signed(r[ry])) ? 16'd1 : 16'd0;
						default: wr = 1'b0;
					endcase
				end
				cpu_pkg::OP_LW: res = dm[addr % DMEM_WORDS];
				cpu_pkg::OP_SW: begin
					dm[addr % DMEM_WORDS] = r[rx];
					wr = 1'b0;
				end
				cpu_pkg::OP_B: begin
					target = pc + 16'd1 + imm11s;
					wr = 1'b0;
				end
				cpu_pkg::OP_BEQZ: begin
					if (r[rx] == '0) begin
						target = pc + 16'd1 + imm8s;
					end
					wr = 1'b0;
				end
				cpu_pkg::OP_JR: begin
					target = r[rx];
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				r[dst] = res;
				exp_addr_q.push_back(dst);
				exp_value_q.push_back(res);
			end
			pc = npc;
			npc = target;
		end
	endfunction

	initial begin
		seed = 49262;
		rst_n = 1'b0;
		load_program();
		execute_ref();
		limit = BOOT_WORDS * 6 + 20 * exp_addr_q.size();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (exp_idx < exp_addr_q.size()) begin
			@(posedge clk);
		end
		// Core should now spin in the halt loop without writes
		repeat (20) @(posedge clk);
		$display(">>> PASS");
		$finish;
	end

	// Flash model with 1 to 4 cycles of latency that also checks the read order
	always @(posedge clk) begin
		flash_ready <= 1'b0;
		if (rst_n === 1'b1) begin
			if (pending) begin
				if (flash_rd === 1'b1) begin
					abort_run("a flash read was issued while another was outstanding");
				end
				if (delay == 0) begin
					flash_ready <= 1'b1;
					flash_data <= image[req_addr % BOOT_WORDS];
					pending = 1'b0;
				end else begin
					delay = delay - 1;
				end
			end else if (flash_rd === 1'b1) begin
				check_value("flash_addr", flash_addr, next_addr);
				req_addr = flash_addr;
				next_addr = next_addr + 16'd1;
				reads++;
				delay = $unsigned($random(seed)) % 4;
				pending = 1'b1;
			end
			if (boot_done === 1'b1 && !prev_boot) begin
				check_value("flash reads at boot_done", 16'(reads), 16'(BOOT_WORDS));
			end
			if (boot_done !== 1'b1 && prev_boot) begin
				abort_run("boot_done fell after it had risen");
			end
			prev_boot = (boot_done === 1'b1);
		end
	end

	always @(posedge clk) begin
		if (rst_n === 1'b1 && reg_wr !== 1'b0) begin
			if (reg_wr !== 1'b1) begin
				abort_run("reg_wr is unknown after reset");
			end
			if (boot_done !== 1'b1) begin
				abort_run("a register write appeared before boot finished");
			end
			if (exp_idx >= exp_addr_q.size()) begin
				abort_run("a register write appeared after the program ended");
			end
			check_value("reg_wr_addr", 16'(reg_wr_addr), 16'(exp_addr_q[exp_idx]));
			check_value("reg_wr_value", reg_wr_value, exp_value_q[exp_idx]);
			exp_idx++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			abort_run("timeout, the program did not finish within the cycle limit");
		end
	end

endmodule

/* list.f */
hw/cpu_pkg.sv
hw/alu.sv
hw/word_ram.sv
hw/register_file.sv
hw/bootloader.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/zhxpu.sv
verification/zhxpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= zhxpu_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
